/* src/operand_net_defines.svh */
// Size parameters of the operand network lane.
// Include wherever a width or the bypass depth is needed; the guard makes
// repeated inclusion harmless.

`ifndef OPERAND_NET_DEFINES_SVH
`define OPERAND_NET_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////////////////////
`define NUM_LANES		4			// Lanes in the full array

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////
`define DATA_W			32			// Data word
`define INDEX_W			6			// Register index
`define SLICE_W			6			// Slice length and element number

////////////////////////////////////////////////////////////////////////////
// Bypass storage
////////////////////////////////////////////////////////////////////////////
`define BYPASS_DEPTH	4			// Write-back entries kept for forwarding

`endif

/* src/operand_net_pkg.sv */
// Shared types of the operand network lane.
// Modules import this package inside their body and use scoped names in
// their port lists.

`include "operand_net_defines.svh"

package operand_net_pkg;

	typedef logic [`DATA_W-1:0]		data_t;			// One data word
	typedef logic [`INDEX_W-1:0]	index_t;		// One register index

	// Source of one operand
	typedef enum logic [1:0] {
		path_imm	= 2'd0,							// Command's own data
		path_scalar	= 2'd1,							// Scalar broadcast
		path_left	= 2'd2,							// Left neighbor lane
		path_right	= 2'd3							// Right neighbor lane
	} path_sel_t;

	// Register view of an operand word
	typedef struct packed {
		logic							idx_v;		// Index is valid
		index_t							idx;		// Base register index
		logic [`DATA_W-`INDEX_W-2:0]	pad;		// Unused
	} operand_reg_t;

	// One operand word, immediate or register reference
	typedef union packed {
		data_t			imm;						// Read on path_imm
		operand_reg_t	regv;						// Read on every other path
	} operand_u;

	typedef struct packed {
		operand_u				op1;
		operand_u				op2;
		operand_u				op3;
		path_sel_t				sel1;
		path_sel_t				sel2;
		path_sel_t				sel3;
		logic [`SLICE_W-1:0]	slice_len;			// Zero runs as one element
	} slice_cmd_t;

endpackage

/* src/issue_fsm.sv */
// Issue control of one lane.
// Accepts a command in idle, steps the slice one element per cycle while
// not stalled, and spends one finish cycle before accepting again.

`timescale 1ns/1ps

module issue_fsm (
	input	logic	clock,
	input	logic	rst,
	input	logic	cmd_valid,
	input	logic	stall,
	input	logic	last,			// Counter is on the final element
	output	logic	cmd_ready,
	output	logic	load,			// Capture command, restart counter
	output	logic	advance,
	output	logic	issue,
	output	logic	done			// Final element issued this cycle
);

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_finish
	} state_t;

	state_t	state;
	state_t	state_nxt;

	assign cmd_ready	= (state == st_idle);
	assign load			= cmd_ready && cmd_valid;
	assign issue		= (state == st_issue) && !stall;
	assign advance		= issue;
	assign done			= issue && last;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:	if (load) state_nxt = st_issue;
			st_issue:	if (done) state_nxt = st_finish;
			st_finish:	state_nxt = st_idle;	// Output stage shows last element
			default:	state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	// No second command may be taken before the slice has finished
	a_ready_held_low: assert property (@(posedge clock) disable iff (rst)
		load |=> (!cmd_ready until done))
		else $error("issue_fsm: command port ready during a slice");

endmodule

/* src/slice_counter.sv */
// Element counter of a slice.
// Load takes the slice length and restarts at element 0; each advance
// steps to the next element. Last flags the final element.

`timescale 1ns/1ps
`include "operand_net_defines.svh"

module slice_counter (
	input	logic					clock,
	input	logic					rst,
	input	logic					load,			// New command accepted
	input	logic					advance,		// Element issued
	input	logic [`SLICE_W-1:0]	slice_len,
	output	logic [`SLICE_W-1:0]	elem,
	output	logic					last
);

	logic [`SLICE_W-1:0]	len_q;					// Length of current slice

	always_ff @(posedge clock) begin
		if (rst) begin
			elem	<= '0;
			len_q	<= `SLICE_W'(1);
		end else if (load) begin
			elem	<= '0;
			len_q	<= (slice_len == '0) ? `SLICE_W'(1) : slice_len;	// Zero runs once
		end else if (advance) begin
			elem	<= elem + 1'b1;
		end
	end

	assign last = (elem == len_q - 1'b1);

	// Issue must stop at the last element
	a_elem_in_range: assert property (@(posedge clock) disable iff (rst)
		elem <= len_q)
		else $error("slice_counter: element %0d beyond length %0d", elem, len_q);

endmodule

/* src/lane_path_select.sv */
// Source selection of one lane.
// Picks the data of each of the three operands among the command's
// immediate, the scalar broadcast and the two neighbor lanes, and hands
// the register view of each operand on to the bypass lookup.

`timescale 1ns/1ps
`include "operand_net_defines.svh"

module lane_path_select #(
	parameter int LANE_ID = 0
)(
	input	operand_net_pkg::slice_cmd_t	cmd,
	input	operand_net_pkg::data_t			scalar_data,	// Scalar unit broadcast
	input	operand_net_pkg::data_t			left_data,		// Left neighbor
	input	operand_net_pkg::data_t			right_data,		// Right neighbor
	output	operand_net_pkg::data_t			path1_data,
	output	operand_net_pkg::data_t			path2_data,
	output	operand_net_pkg::data_t			path3_data,
	output	logic							idx_v1,
	output	logic							idx_v2,
	output	logic							idx_v3,
	output	operand_net_pkg::index_t		idx1,
	output	operand_net_pkg::index_t		idx2,
	output	operand_net_pkg::index_t		idx3
);

	import operand_net_pkg::*;

	// Lane id must name a lane of the array
	if (LANE_ID < 0 || LANE_ID >= `NUM_LANES) begin : g_bad_lane
		$error("lane_path_select: LANE_ID %0d outside 0..%0d", LANE_ID, `NUM_LANES - 1);
	end

	function automatic data_t pick_data(
		input path_sel_t	sel,
		input operand_u		op,
		input data_t		scalar_in,
		input data_t		left_in,
		input data_t		right_in
	);
		data_t val;
		case (sel)
			path_imm:		val = op.imm;
			path_scalar:	val = scalar_in;
			path_left:		val = left_in;
			default:		val = right_in;
		endcase
		return val;
	endfunction

	always_comb begin
		path1_data	= pick_data(cmd.sel1, cmd.op1, scalar_data, left_data, right_data);
		path2_data	= pick_data(cmd.sel2, cmd.op2, scalar_data, left_data, right_data);
		path3_data	= pick_data(cmd.sel3, cmd.op3, scalar_data, left_data, right_data);

		// An immediate carries no register reference
		idx_v1		= (cmd.sel1 != path_imm) && cmd.op1.regv.idx_v;
		idx_v2		= (cmd.sel2 != path_imm) && cmd.op2.regv.idx_v;
		idx_v3		= (cmd.sel3 != path_imm) && cmd.op3.regv.idx_v;
		idx1		= cmd.op1.regv.idx;
		idx2		= cmd.op2.regv.idx;
		idx3		= cmd.op3.regv.idx;
	end

endmodule

/* src/bypass_buffer.sv */
// Bypass buffer of one lane.
// Keeps recent write-backs in arrival order and forwards the newest entry
// whose index matches an operand's base index plus the element number.
// The three operands, the element number and the valid flag are
// registered here on each issue cycle.

`timescale 1ns/1ps
`include "operand_net_defines.svh"

module bypass_buffer (
	input	logic						clock,
	input	logic						rst,
	input	logic						issue,			// Register one element
	input	logic						clear,			// Drop all entries
	input	logic						wb_valid,
	input	operand_net_pkg::index_t	wb_index,
	input	operand_net_pkg::data_t		wb_data,
	input	logic [`SLICE_W-1:0]		elem,
	input	logic						idx_v1,
	input	logic						idx_v2,
	input	logic						idx_v3,
	input	operand_net_pkg::index_t	idx1,
	input	operand_net_pkg::index_t	idx2,
	input	operand_net_pkg::index_t	idx3,
	input	operand_net_pkg::data_t		path1_data,
	input	operand_net_pkg::data_t		path2_data,
	input	operand_net_pkg::data_t		path3_data,
	output	operand_net_pkg::data_t		src_data1,
	output	operand_net_pkg::data_t		src_data2,
	output	operand_net_pkg::data_t		src_data3,
	output	logic [`SLICE_W-1:0]		out_elem,
	output	logic						out_valid,
	output	logic						buff_full
);

	import operand_net_pkg::*;

	localparam int CNT_W = $clog2(`BYPASS_DEPTH + 1);
	localparam int PTR_W = (`BYPASS_DEPTH > 1) ? $clog2(`BYPASS_DEPTH) : 1;

	index_t				ent_index [`BYPASS_DEPTH];		// Oldest at 0
	data_t				ent_data  [`BYPASS_DEPTH];
	logic [CNT_W-1:0]	ent_cnt;						// Entries held
	logic [PTR_W-1:0]	wr_ptr;
	logic				wb_take;
	data_t				fwd1;
	data_t				fwd2;
	data_t				fwd3;

	assign buff_full	= (ent_cnt == CNT_W'(`BYPASS_DEPTH));
	assign wb_take		= wb_valid && !buff_full;
	assign wr_ptr		= clear ? '0 : ent_cnt[PTR_W-1:0];	// Restart at 0 on clear

	// Newest match wins; a write-back in this cycle beats every stored entry
	function automatic data_t lookup(input logic idx_v, input index_t base, input data_t path);
		index_t	eff;
		data_t	val;
		eff = base + index_t'(elem);						// Wraps modulo 64
		val = path;
		if (idx_v) begin
			for (int i = 0; i < `BYPASS_DEPTH; i++) begin
				if (i < ent_cnt && ent_index[i] == eff)
					val = ent_data[i];
			end
			if (wb_take && wb_index == eff)
				val = wb_data;
		end
		return val;
	endfunction

	always_comb begin
		fwd1 = lookup(idx_v1, idx1, path1_data);
		fwd2 = lookup(idx_v2, idx2, path2_data);
		fwd3 = lookup(idx_v3, idx3, path3_data);
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry store
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst)
			ent_cnt <= '0;
		else if (clear)
			ent_cnt <= wb_take ? CNT_W'(1) : '0;	// Keep a write-back of the clear cycle
		else if (wb_take)
			ent_cnt <= ent_cnt + 1'b1;
	end

	always_ff @(posedge clock) begin
		if (wb_take) begin
			ent_index[wr_ptr]	<= wb_index;
			ent_data[wr_ptr]	<= wb_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= issue;
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			src_data1	<= fwd1;
			src_data2	<= fwd2;
			src_data3	<= fwd3;
			out_elem	<= elem;
		end
	end

	// Caller must hold write-backs while the buffer is full
	a_no_wb_when_full: assert property (@(posedge clock) disable iff (rst)
		buff_full |-> !wb_valid)
		else $error("bypass_buffer: write-back offered while full");

endmodule

/* src/operand_network.sv */
// One lane of the vector engine's operand network.
// Takes a slice command on a valid/ready port, issues one element per
// cycle with forwarded operands, and flags the last element with done.

`timescale 1ns/1ps
`include "operand_net_defines.svh"

module operand_network #(
	parameter int LANE_ID = 0
)(
	input	logic							clock,
	input	logic							rst,
	input	logic							cmd_valid,
	input	operand_net_pkg::slice_cmd_t	cmd,
	output	logic							cmd_ready,
	input	logic							stall,
	input	operand_net_pkg::data_t			scalar_data,
	input	operand_net_pkg::data_t			left_data,
	input	operand_net_pkg::data_t			right_data,
	input	logic							wb_valid,
	input	operand_net_pkg::index_t		wb_index,
	input	operand_net_pkg::data_t			wb_data,
	output	operand_net_pkg::data_t			src_data1,		// To execution unit
	output	operand_net_pkg::data_t			src_data2,
	output	operand_net_pkg::data_t			src_data3,
	output	logic [`SLICE_W-1:0]			out_elem,
	output	logic							out_valid,
	output	logic							done,
	output	logic							buff_full
);

	import operand_net_pkg::*;

	slice_cmd_t				cmd_q;							// Command being issued
	logic					load, advance, issue, last, fsm_done;
	logic [`SLICE_W-1:0]	elem;
	data_t					path1_data, path2_data, path3_data;
	logic					idx_v1, idx_v2, idx_v3;
	index_t					idx1, idx2, idx3;

	always_ff @(posedge clock) begin
		if (load)
			cmd_q <= cmd;
	end

	// Done lines up with the registered last element
	always_ff @(posedge clock) begin
		if (rst)
			done <= 1'b0;
		else
			done <= fsm_done;
	end

	issue_fsm u_fsm (.clock(clock), .rst(rst), .cmd_valid(cmd_valid), .stall(stall),
		.last(last), .cmd_ready(cmd_ready), .load(load), .advance(advance),
		.issue(issue), .done(fsm_done));

	slice_counter u_cnt (.clock(clock), .rst(rst), .load(load), .advance(advance),
		.slice_len(cmd.slice_len), .elem(elem), .last(last));

	lane_path_select #(.LANE_ID(LANE_ID)) u_path (.cmd(cmd_q), .scalar_data(scalar_data),
		.left_data(left_data), .right_data(right_data), .path1_data(path1_data),
		.path2_data(path2_data), .path3_data(path3_data), .idx_v1(idx_v1),
		.idx_v2(idx_v2), .idx_v3(idx_v3), .idx1(idx1), .idx2(idx2), .idx3(idx3));

	bypass_buffer u_byp (.clock(clock), .rst(rst), .issue(issue), .clear(done),
		.wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data), .elem(elem),
		.idx_v1(idx_v1), .idx_v2(idx_v2), .idx_v3(idx_v3),
		.idx1(idx1), .idx2(idx2), .idx3(idx3),
		.path1_data(path1_data), .path2_data(path2_data), .path3_data(path3_data),
		.src_data1(src_data1), .src_data2(src_data2), .src_data3(src_data3),
		.out_elem(out_elem), .out_valid(out_valid), .buff_full(buff_full));

endmodule

/* test/tb_operand_network.sv */
// Directed testbench of one operand network lane.
// Runs reset, path selection, slice timing, bypass forwarding, stall and
// buffer-full tests against operand_network, one task per test.

`timescale 1ns/1ps
`include "operand_net_defines.svh"

module tb_operand_network;

	import operand_net_pkg::*;

	logic					clock;
	logic					rst;
	logic					cmd_valid;
	slice_cmd_t				cmd;
	logic					cmd_ready;
	logic					stall;
	data_t					scalar_data;
	data_t					left_data;
	data_t					right_data;
	logic					wb_valid;
	index_t					wb_index;
	data_t					wb_data;
	data_t					src_data1;
	data_t					src_data2;
	data_t					src_data3;
	logic [`SLICE_W-1:0]	out_elem;
	logic					out_valid;
	logic					done;
	logic					buff_full;

	int						errs = 0;				// Errors of the running test
	int						tests_ok = 0;
	int						tests_bad = 0;
	data_t					q_d1[$];				// Captured elements of a slice
	data_t					q_d2[$];
	data_t					q_d3[$];
	logic [`SLICE_W-1:0]	q_elem[$];
	int						q_cyc[$];				// Cycle of each element after accept
	int						done_cyc;

	operand_network #(.LANE_ID(1)) uut (.clock(clock), .rst(rst), .cmd_valid(cmd_valid),
		.cmd(cmd), .cmd_ready(cmd_ready), .stall(stall), .scalar_data(scalar_data),
		.left_data(left_data), .right_data(right_data), .wb_valid(wb_valid),
		.wb_index(wb_index), .wb_data(wb_data), .src_data1(src_data1),
		.src_data2(src_data2), .src_data3(src_data3), .out_elem(out_elem),
		.out_valid(out_valid), .done(done), .buff_full(buff_full));

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;					// 4 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic tick();
		@(posedge clock);
		#1;											// Drive and sample here
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			errs++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_elem(input string name, input logic [`SLICE_W-1:0] got,
			input logic [`SLICE_W-1:0] exp);
		if (got !== exp) begin
			errs++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errs++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		if (errs == 0) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errs);
		end
		errs = 0;
	endtask

	task automatic write_wb(input index_t idx, input data_t val);
		if (buff_full) begin
			errs++;
			$display("write-back to index %h not offered because the buffer is full", idx);
			return;
		end
		wb_valid	= 1'b1;
		wb_index	= idx;
		wb_data		= val;
		tick();
		wb_valid	= 1'b0;
	endtask

	task automatic send_cmd(input slice_cmd_t c);
		int n;
		n = 0;
		while (!cmd_ready && n < 50) begin
			tick();
			n++;
		end
		if (!cmd_ready) begin
			errs++;
			$display("cmd_ready did not rise within 50 cycles, command not sent");
			return;
		end
		cmd			= c;
		cmd_valid	= 1'b1;
		tick();										// Accepted on this edge
		cmd_valid	= 1'b0;
	endtask

	// Sends a command and captures every valid element until done
	task automatic run_slice(input slice_cmd_t c, input int stall_from, input int stall_len);
		int		cyc;
		logic	stalled_prev;
		q_d1.delete();
		q_d2.delete();
		q_d3.delete();
		q_elem.delete();
		q_cyc.delete();
		done_cyc		= -1;
		cyc				= 0;
		stalled_prev	= 1'b0;
		send_cmd(c);
		while (done_cyc < 0 && cyc < 64) begin
			tick();
			cyc++;
			if (stalled_prev && out_valid) begin
				errs++;
				$display("element %0d came out in a cycle that was stalled", out_elem);
			end
			if (out_valid) begin
				q_d1.push_back(src_data1);
				q_d2.push_back(src_data2);
				q_d3.push_back(src_data3);
				q_elem.push_back(out_elem);
				q_cyc.push_back(cyc);
			end
			if (done) begin
				done_cyc = cyc;
				check_flag("out_valid with done", out_valid, 1'b1);
			end
			stall			= (cyc >= stall_from) && (cyc < stall_from + stall_len);
			stalled_prev	= stall;
		end
		stall = 1'b0;
		if (done_cyc < 0) begin
			errs++;
			$display("slice did not raise done within 64 cycles");
		end
	endtask

	// Elements 0..n-1 in order and once each, with done on the last
	task automatic check_stream(input int n);
		check_elem("valid count", `SLICE_W'(q_elem.size()), `SLICE_W'(n));
		for (int k = 0; k < q_elem.size(); k++)
			check_elem("out_elem", q_elem[k], `SLICE_W'(k));
		if (q_cyc.size() > 0)
			check_elem("done cycle", `SLICE_W'(done_cyc), `SLICE_W'(q_cyc[q_cyc.size() - 1]));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////
	task automatic test_reset_state();
		check_flag("cmd_ready", cmd_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("buff_full", buff_full, 1'b0);
		end_test("reset state");
	endtask

	task automatic test_four_paths();
		slice_cmd_t	c;
		data_t		imm;
		c			= '0;
		imm			= $urandom;
		scalar_data	= $urandom;
		left_data	= $urandom;
		right_data	= $urandom;
		c.op1.imm	= imm;
		c.sel1		= path_imm;
		c.op2.imm	= $urandom;						// Random register view on an empty buffer
		c.sel2		= path_scalar;
		c.op3.imm	= $urandom;
		c.sel3		= path_left;
		c.slice_len	= 1;
		run_slice(c, 99, 0);
		check_stream(1);
		if (q_d1.size() > 0) begin
			check_data("src_data1", q_d1[0], imm);
			check_data("src_data2", q_d2[0], scalar_data);
			check_data("src_data3", q_d3[0], left_data);
		end
		c.sel3		= path_right;
		c.slice_len	= 0;							// Runs as one element
		run_slice(c, 99, 0);
		check_stream(1);
		if (q_d3.size() > 0)
			check_data("src_data3", q_d3[0], right_data);
		end_test("four paths");
	endtask

	task automatic test_slice_timing();
		slice_cmd_t c;
		c			= '0;
		c.op1.imm	= $urandom;
		c.slice_len	= 5;
		run_slice(c, 99, 0);
		check_stream(5);
		for (int k = 0; k < q_cyc.size(); k++) begin
			check_elem("cycle of out_elem", `SLICE_W'(q_cyc[k]), `SLICE_W'(k + 1));
			check_data("src_data1", q_d1[k], c.op1.imm);
		end
		tick();
		check_flag("cmd_ready", cmd_ready, 1'b1);
		end_test("slice timing");
	endtask

	task automatic test_bypass_forward();
		slice_cmd_t	c;
		index_t		b;
		data_t		old_v;
		data_t		new_v;
		b			= index_t'($urandom);
		old_v		= $urandom;
		new_v		= $urandom;
		scalar_data	= $urandom;
		left_data	= $urandom;
		write_wb(index_t'(b + 2), old_v);
		write_wb(index_t'(b + 2), new_v);
		write_wb(index_t'(b + 9), $urandom);		// Out of reach of 4 elements
		c					= '0;
		c.op1.regv.idx_v	= 1'b1;
		c.op1.regv.idx		= b;
		c.sel1				= path_scalar;
		c.op2.regv.idx_v	= 1'b0;					// Same base with lookup disabled
		c.op2.regv.idx		= b;
		c.sel2				= path_left;
		c.op3.imm			= $urandom;
		c.sel3				= path_imm;
		c.slice_len			= 4;
		run_slice(c, 99, 0);
		check_stream(4);
		for (int k = 0; k < q_d1.size(); k++) begin
			check_data("src_data1", q_d1[k], (k == 2) ? new_v : scalar_data);
			check_data("src_data2", q_d2[k], left_data);
			check_data("src_data3", q_d3[k], c.op3.imm);
		end
		end_test("bypass forward");
	endtask

	task automatic test_stall();
		slice_cmd_t c;
		c			= '0;
		right_data	= $urandom;
		c.sel1		= path_right;
		c.slice_len	= 6;
		run_slice(c, 3, 3);							// Stall cycles 3 to 5
		check_stream(6);
		if (q_cyc.size() > 0)
			check_elem("cycle of last element", `SLICE_W'(q_cyc[q_cyc.size() - 1]), 6'd9);
		for (int k = 0; k < q_d1.size(); k++)
			check_data("src_data1", q_d1[k], right_data);
		end_test("stall");
	endtask

	task automatic test_buffer_full();
		slice_cmd_t c;
		for (int i = 0; i < `BYPASS_DEPTH; i++)
			write_wb(index_t'(i * 7 + 1), $urandom);
		check_flag("buff_full", buff_full, 1'b1);
		c			= '0;
		c.op1.imm	= $urandom;
		c.slice_len	= 2;
		run_slice(c, 99, 0);
		check_stream(2);
		for (int k = 0; k < q_d1.size(); k++)
			check_data("src_data1", q_d1[k], c.op1.imm);
		tick();										// Entries drop after done
		check_flag("buff_full", buff_full, 1'b0);
		end_test("buffer full");
	endtask

	initial begin
		void'($urandom(32'h0635_7155));
		rst			= 1'b1;
		cmd_valid	= 1'b0;
		cmd			= '0;
		stall		= 1'b0;
		scalar_data	= '0;
		left_data	= '0;
		right_data	= '0;
		wb_valid	= 1'b0;
		wb_index	= '0;
		wb_data		= '0;
		repeat (16) @(posedge clock);
		#1 rst		= 1'b0;
		test_reset_state();
		test_four_paths();
		test_slice_timing();
		test_bypass_forward();
		test_stall();
		test_buffer_full();
		$display("tests ok: %0d, tests with errors: %0d", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* operand_net.f */
+incdir+src
src/operand_net_pkg.sv
src/issue_fsm.sv
src/slice_counter.sv
src/lane_path_select.sv
src/bypass_buffer.sv
src/operand_network.sv
test/tb_operand_network.sv

/* Bender.yml */
package:
  name: operand_net

sources:
  - include_dirs:
      - src
    files:
      - src/operand_net_pkg.sv
      - src/issue_fsm.sv
      - src/slice_counter.sv
      - src/lane_path_select.sv
      - src/bypass_buffer.sv
      - src/operand_network.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_operand_network.sv
